//--- Makefile
# Verilator build and run of the realigner testbench

VERILATOR ?= verilator
TOP       ?= tb_realign
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG) || ! grep -q "TEST PASS" $(LOG); then \
		echo "simulation reported failure, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- design/byte_realigner.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// byte realignment of a tagged beat stream
// each word takes its low bytes from the held beat
// and the rest from the current one; result is
// registered, one cycle after the producing beat
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module byte_realigner import realign_pkg::*; (
  input  wire logic  clk_i,
  input  wire logic  rst_ni,
  input  wire logic  beat_valid_i,
  input  wire word_t beat_data_i,
  input  wire logic  beat_first_i,
  input  wire logic  beat_last_i,
  input  wire rot_t  beat_rot_i,
  output logic       word_valid_o,
  output word_t      word_data_o,
  output logic       word_last_o
);

  localparam int unsigned W = $bits(word_t);

  word_t  hold_q;
  word_t  aligned;
  logic   produce;

  logic        word_valid_q;
  logic        word_last_q;
  word_t       word_data_q;

  logic [2*W-1:0] pair;
  logic [2*W-1:0] shifted;

  // previous beat sits in the low half, so a right shift by r bytes
  // pulls hold[b+r] into byte b and wraps into the current beat
  assign pair    = {beat_data_i, hold_q};
  assign shifted = pair >> (8 * beat_rot_i);

  always_comb begin
    if (beat_rot_i == '0) begin
      aligned = beat_data_i;
    end else begin
      aligned = shifted[W-1:0];
    end
  end

  // first beat of a rotated line only primes the hold register
  assign produce = beat_valid_i & ((beat_rot_i == '0) | ~beat_first_i);

  always_ff @(posedge clk_i) begin
    if (beat_valid_i) begin
      hold_q <= beat_data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      word_valid_q <= 1'b0;
      word_last_q  <= 1'b0;
    end else begin
      word_valid_q <= produce;
      word_last_q  <= produce & beat_last_i;
    end
  end

  // payload only
  always_ff @(posedge clk_i) begin
    if (produce) begin
      word_data_q <= aligned;
    end
  end

  assign word_valid_o = word_valid_q;
  assign word_last_o  = word_last_q;
  assign word_data_o  = word_data_q;

endmodule

`default_nettype wire

//--- design/realign_cmd_fifo.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// queue of pending line commands (rotation, length)
// head is visible combinationally; pushes while full
// are ignored and pops while empty do nothing
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module realign_cmd_fifo import realign_pkg::*; #(
  parameter int unsigned DEPTH = 4
) (
  input  wire logic      clk_i,
  input  wire logic      rst_ni,
  input  wire logic      push_i,
  input  wire rot_t      push_rot_i,
  input  wire line_len_t push_len_i,
  input  wire logic      pop_i,
  output logic           empty_o,
  output logic           full_o,
  output rot_t           head_rot_o,
  output line_len_t      head_len_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = PTR_W + 1;

  rot_t      rot_mem [DEPTH];
  line_len_t len_mem [DEPTH];

  logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             do_push, do_pop;

  assign full_o  = (count_q == CNT_W'(DEPTH));
  assign empty_o = (count_q == '0);

  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;

  // storage, no reset needed since count guards every read
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      rot_mem[wr_ptr_q] <= push_rot_i;
      len_mem[wr_ptr_q] <= push_len_i;
    end
  end

  // pointers wrap by themselves, depth is a power of two
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (do_pop)  rd_ptr_q <= rd_ptr_q + 1'b1;
      count_q <= count_q + CNT_W'(do_push) - CNT_W'(do_pop);
    end
  end

  assign head_rot_o = rot_mem[rd_ptr_q];
  assign head_len_o = len_mem[rd_ptr_q];

endmodule

`default_nettype wire

//--- design/realign_output.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// output register stage of the realigner
// drives the consumer one cycle after the aligned
// word and counts lines as their last word leaves
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module realign_output import realign_pkg::*; (
  input  wire logic  clk_i,
  input  wire logic  rst_ni,
  input  wire logic  word_valid_i,
  input  wire word_t word_data_i,
  input  wire logic  word_last_i,
  output logic       out_valid_o,
  output word_t      out_data_o,
  output logic       out_last_o,
  output logic [15:0] lines_done_o
);

  logic        out_valid_q;
  logic        out_last_q;
  word_t       out_data_q;
  logic [15:0] lines_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      out_valid_q <= 1'b0;
      out_last_q  <= 1'b0;
    end else begin
      out_valid_q <= word_valid_i;
      out_last_q  <= word_valid_i & word_last_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (word_valid_i) begin
      out_data_q <= word_data_i;
    end
  end

  // wraps at 16 bits
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lines_q <= '0;
    end else if (out_last_q) begin
      lines_q <= lines_q + 16'd1;
    end
  end

  assign out_valid_o  = out_valid_q;
  assign out_last_o   = out_last_q;
  assign out_data_o   = out_data_q;
  assign lines_done_o = lines_q;

endmodule

`default_nettype wire

//--- design/realign_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared types of the realigning stream source
// import with a wildcard in the module header
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "realign_settings.svh"

package realign_pkg;

  // bytes per data word
  localparam int unsigned byte_lanes = `REALIGN_DATA_W / 8;

  // rotation field width, kept at one bit for single-lane words
  localparam int unsigned rot_w = (byte_lanes > 1) ? $clog2(byte_lanes) : 1;

  // byte offset of the line start inside its first input word
  typedef logic [rot_w-1:0] rot_t;

  // aligned output words per line, zero is not a legal command
  typedef logic [`REALIGN_LEN_W-1:0] line_len_t;

  // input beats per line, one more bit since rotated lines need L+1
  typedef logic [`REALIGN_LEN_W:0] beat_cnt_t;

  typedef logic [`REALIGN_DATA_W-1:0] word_t;

endpackage

`default_nettype wire

//--- design/realign_sequencer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// input side of the realigner
// pops one command at a time while idle, counts the
// beats of the active line and tags them first/last;
// beats seen while idle are dropped and flagged
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module realign_sequencer import realign_pkg::*; (
  input  wire logic      clk_i,
  input  wire logic      rst_ni,
  // raw input beats
  input  wire logic      in_valid_i,
  input  wire word_t     in_data_i,
  // command queue head
  input  wire logic      q_empty_i,
  input  wire rot_t      q_rot_i,
  input  wire line_len_t q_len_i,
  output logic           q_pop_o,
  // status
  output logic           line_active_o,
  output logic           stray_o,
  // tagged beats toward the realigner
  output logic           beat_valid_o,
  output word_t          beat_data_o,
  output logic           beat_first_o,
  output logic           beat_last_o,
  output rot_t           beat_rot_o
);

  logic      active_q;
  rot_t      rot_q;
  beat_cnt_t beats_q;
  beat_cnt_t cnt_q;
  logic      stray_q;

  beat_cnt_t last_idx;
  logic      accept;
  logic      is_last;

  // a new line may start in the cycle right after the previous one ends
  assign q_pop_o = ~active_q & ~q_empty_i;

  assign accept   = in_valid_i & active_q;
  assign last_idx = beats_q - beat_cnt_t'(1);
  assign is_last  = (cnt_q == last_idx);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      active_q <= 1'b0;
      cnt_q    <= '0;
    end else if (q_pop_o) begin
      active_q <= 1'b1;
      cnt_q    <= '0;
    end else if (accept) begin
      if (is_last) begin
        active_q <= 1'b0;
        cnt_q    <= '0;
      end else begin
        cnt_q <= cnt_q + beat_cnt_t'(1);
      end
    end
  end

  // command fields, captured once when the line loads
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rot_q   <= '0;
      beats_q <= '0;
    end else if (q_pop_o) begin
      rot_q <= q_rot_i;
      // rotated lines straddle one extra input word
      beats_q <= beat_cnt_t'(q_len_i) + beat_cnt_t'(q_rot_i != '0);
    end
  end

  // beat with no active line
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      stray_q <= 1'b0;
    end else begin
      stray_q <= in_valid_i & ~active_q;
    end
  end

  assign line_active_o = active_q;
  assign stray_o       = stray_q;

  assign beat_valid_o = accept;
  assign beat_data_o  = in_data_i;
  assign beat_first_o = accept & (cnt_q == '0);
  assign beat_last_o  = accept & is_last;
  assign beat_rot_o   = rot_q;

endmodule

`default_nettype wire

//--- design/realign_settings.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// build-time sizing for the realigning stream source
// include wherever word width, length field or queue
// depth are needed; override before first include
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef REALIGN_SETTINGS_SVH
`define REALIGN_SETTINGS_SVH

// data word width in bits, multiple of 8
`define REALIGN_DATA_W 32

// width of the line-length field in a command
`define REALIGN_LEN_W 8

// pending command slots, power of two, at least 2
`define REALIGN_CMD_DEPTH 4

`endif

//--- design/realign_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// realigning stream source, top level
// commands queue up, one line at a time is realigned
// from rotated input beats into aligned output words
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "realign_settings.svh"

module realign_top import realign_pkg::*; (
  input  wire logic      clk_i,
  input  wire logic      rst_ni,
  // line commands
  input  wire logic      cmd_valid_i,
  input  wire rot_t      cmd_rot_i,
  input  wire line_len_t cmd_len_i,
  // data input
  input  wire logic      in_valid_i,
  input  wire word_t     in_data_i,
  // aligned output
  output logic           out_valid_o,
  output word_t          out_data_o,
  output logic           out_last_o,
  // status
  output logic           cmd_full_o,
  output logic           line_active_o,
  output logic           stray_o,
  output logic           cmd_drop_o,
  output logic [15:0]    lines_done_o
);

  logic      q_push, q_pop, q_empty, q_full;
  rot_t      q_rot;
  line_len_t q_len;
  logic      cmd_bad;
  logic      cmd_drop_q;

  logic      beat_valid, beat_first, beat_last;
  word_t     beat_data;
  rot_t      beat_rot;

  logic      word_valid, word_last;
  word_t     word_data;

  // full queue or zero length means the command is lost
  assign cmd_bad = q_full | (cmd_len_i == '0);
  assign q_push  = cmd_valid_i & ~cmd_bad;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cmd_drop_q <= 1'b0;
    end else begin
      cmd_drop_q <= cmd_valid_i & cmd_bad;
    end
  end

  assign cmd_drop_o = cmd_drop_q;
  assign cmd_full_o = q_full;

  realign_cmd_fifo #(
    .DEPTH ( `REALIGN_CMD_DEPTH )
  ) i_cmd_fifo (
    .clk_i      ( clk_i     ),
    .rst_ni     ( rst_ni    ),
    .push_i     ( q_push    ),
    .push_rot_i ( cmd_rot_i ),
    .push_len_i ( cmd_len_i ),
    .pop_i      ( q_pop     ),
    .empty_o    ( q_empty   ),
    .full_o     ( q_full    ),
    .head_rot_o ( q_rot     ),
    .head_len_o ( q_len     )
  );

  realign_sequencer i_sequencer (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .in_valid_i    ( in_valid_i    ),
    .in_data_i     ( in_data_i     ),
    .q_empty_i     ( q_empty       ),
    .q_rot_i       ( q_rot         ),
    .q_len_i       ( q_len         ),
    .q_pop_o       ( q_pop         ),
    .line_active_o ( line_active_o ),
    .stray_o       ( stray_o       ),
    .beat_valid_o  ( beat_valid    ),
    .beat_data_o   ( beat_data     ),
    .beat_first_o  ( beat_first    ),
    .beat_last_o   ( beat_last     ),
    .beat_rot_o    ( beat_rot      )
  );

  byte_realigner i_realigner (
    .clk_i        ( clk_i      ),
    .rst_ni       ( rst_ni     ),
    .beat_valid_i ( beat_valid ),
    .beat_data_i  ( beat_data  ),
    .beat_first_i ( beat_first ),
    .beat_last_i  ( beat_last  ),
    .beat_rot_i   ( beat_rot   ),
    .word_valid_o ( word_valid ),
    .word_data_o  ( word_data  ),
    .word_last_o  ( word_last  )
  );

  realign_output i_output (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .word_valid_i ( word_valid   ),
    .word_data_i  ( word_data    ),
    .word_last_i  ( word_last    ),
    .out_valid_o  ( out_valid_o  ),
    .out_data_o   ( out_data_o   ),
    .out_last_o   ( out_last_o   ),
    .lines_done_o ( lines_done_o )
  );

endmodule

`default_nettype wire

//--- flist.f
+incdir+design
design/realign_pkg.sv
design/realign_cmd_fifo.sv
design/realign_sequencer.sv
design/byte_realigner.sv
design/realign_output.sv
design/realign_top.sv
sim/realign_props.sv
sim/tb_realign.sv

//--- sim/realign_props.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// protocol properties of the realigner top level
// bound into realign_top, flags violations with $error
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module realign_props (
  input wire logic        clk_i,
  input wire logic        rst_ni,
  input wire logic        out_valid_o,
  input wire logic        out_last_o,
  input wire logic        stray_o,
  input wire logic [15:0] lines_done_o
);

  // a last flag never comes without its word
  last_needs_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    out_last_o |-> out_valid_o)
    else $error("out_last_o high without out_valid_o");

  known_flags: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !$isunknown({stray_o, out_valid_o}))
    else $error("stray_o or out_valid_o unknown after reset");

  // counter moves one cycle after a line end
  count_after_last: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (lines_done_o != $past(lines_done_o)) |-> $past(out_last_o))
    else $error("lines_done_o changed without a preceding out_last_o");

endmodule

bind realign_top realign_props i_props (
  .clk_i        ( clk_i        ),
  .rst_ni       ( rst_ni       ),
  .out_valid_o  ( out_valid_o  ),
  .out_last_o   ( out_last_o   ),
  .stray_o      ( stray_o      ),
  .lines_done_o ( lines_done_o )
);

`default_nettype wire

//--- sim/tb_realign.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for realign_top
// table of lines, a queue overflow burst and a stray
// beat; words checked against a byte-rotation model,
// including the two-cycle latency
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "realign_settings.svh"

module tb_realign import realign_pkg::*; ();

  localparam int TIMEOUT = 200;
  localparam int NROWS   = 16;

  logic        clk = 1'b0;
  logic        rst_n;
  logic        cmd_valid, in_valid;
  rot_t        cmd_rot;
  line_len_t   cmd_len;
  word_t       in_data;
  logic        out_valid, out_last, cmd_full, line_active, stray, cmd_drop;
  word_t       out_data;
  logic [15:0] lines_done;

  word_t       exp_word_q [$];
  logic        exp_last_q [$];
  int unsigned exp_cyc_q  [$];
  int unsigned cycle    = 0;
  int unsigned accepted = 0;

  // rotation, length, expect drop
  int rows [NROWS][3] = '{
    '{0, 1, 0}, '{0, 3, 0}, '{0, 0, 1}, '{2, 0, 1},
    '{1, 1, 0}, '{1, 2, 0}, '{1, 3, 0}, '{1, 4, 0},
    '{2, 1, 0}, '{2, 2, 0}, '{2, 3, 0}, '{2, 4, 0},
    '{3, 1, 0}, '{3, 2, 0}, '{3, 3, 0}, '{3, 4, 0}
  };

  always #4 clk = ~clk;

  always @(posedge clk) cycle <= cycle + 1;

  realign_top i_realign_top (
    .clk_i         ( clk         ),
    .rst_ni        ( rst_n       ),
    .cmd_valid_i   ( cmd_valid   ),
    .cmd_rot_i     ( cmd_rot     ),
    .cmd_len_i     ( cmd_len     ),
    .in_valid_i    ( in_valid    ),
    .in_data_i     ( in_data     ),
    .out_valid_o   ( out_valid   ),
    .out_data_o    ( out_data    ),
    .out_last_o    ( out_last    ),
    .cmd_full_o    ( cmd_full    ),
    .line_active_o ( line_active ),
    .stray_o       ( stray       ),
    .cmd_drop_o    ( cmd_drop    ),
    .lines_done_o  ( lines_done  )
  );

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("TEST FAIL");
    $fatal(1, "simulation stopped on first error");
  endtask

  // byte b comes from lo[b+r], or from hi once b+r runs past the word
  function automatic word_t aligned_word(input word_t lo, input word_t hi, input rot_t rot);
    word_t w;
    int    s;
    for (int b = 0; b < int'(byte_lanes); b++) begin
      s = b + int'(rot);
      if (s < int'(byte_lanes)) begin
        w[8*b +: 8] = lo[8*s +: 8];
      end else begin
        w[8*b +: 8] = hi[8*(s - int'(byte_lanes)) +: 8];
      end
    end
    return w;
  endfunction

  // word due three edges after the drive edge of its completing beat
  task automatic expect_word(input word_t w, input logic last);
    exp_word_q.push_back(w);
    exp_last_q.push_back(last);
    exp_cyc_q.push_back(cycle + 3);
  endtask

  task automatic wait_active();
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
      if (n > TIMEOUT) fail_run("timeout while waiting for line_active_o to rise");
    end while (!line_active);
  endtask

  task automatic wait_drained();
    int n;
    n = 0;
    while (exp_word_q.size() != 0) begin
      @(negedge clk);
      n++;
      if (n > TIMEOUT) fail_run("timeout while waiting for the remaining output words");
    end
  endtask

  task automatic issue_cmd(input rot_t rot, input line_len_t len, input logic drop);
    @(posedge clk);
    cmd_valid <= 1'b1;
    cmd_rot   <= rot;
    cmd_len   <= len;
    @(posedge clk);
    cmd_valid <= 1'b0;
    @(negedge clk);
    assert (cmd_drop == drop)
      else fail_run($sformatf("ERR %0t: cmd_drop_o %b, expected %b", $time, cmd_drop, drop));
    if (!drop) accepted++;
  endtask

  task automatic run_line(input rot_t rot, input line_len_t len);
    word_t prev;
    word_t cur;
    int    nb;
    nb = int'(len) + ((rot != '0) ? 1 : 0);
    wait_active();
    for (int k = 0; k < nb; k++) begin
      @(posedge clk);
      cur = word_t'($urandom());
      in_valid <= 1'b1;
      in_data  <= cur;
      if (rot == '0) begin
        expect_word(aligned_word(cur, cur, rot), k == nb - 1);
      end else if (k > 0) begin
        expect_word(aligned_word(prev, cur, rot), k == nb - 1);
      end
      prev = cur;
    end
    @(posedge clk);
    in_valid <= 1'b0;
    // line must close right after its last beat
    @(negedge clk);
    assert (!line_active)
      else fail_run($sformatf("ERR %0t: line still active after %0d beats", $time, nb));
  endtask

  always @(negedge clk) begin
    if (rst_n && out_valid) begin
      assert (exp_word_q.size() > 0)
        else fail_run($sformatf("ERR %0t: unexpected output word %h", $time, out_data));
      assert (out_data == exp_word_q[0] && out_last == exp_last_q[0]
              && cycle == exp_cyc_q[0])
        else fail_run($sformatf("ERR %0t: got %h last %b cycle %0d, expected %h last %b cycle %0d",
                                $time, out_data, out_last, cycle,
                                exp_word_q[0], exp_last_q[0], exp_cyc_q[0]));
      void'(exp_word_q.pop_front());
      void'(exp_last_q.pop_front());
      void'(exp_cyc_q.pop_front());
    end
  end

  initial begin
    void'($urandom(32'hdbb7));
    rst_n     = 1'b0;
    cmd_valid = 1'b0;
    cmd_rot   = '0;
    cmd_len   = '0;
    in_valid  = 1'b0;
    in_data   = '0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;

    for (int r = 0; r < NROWS; r++) begin
      issue_cmd(rot_t'(rows[r][0]), line_len_t'(rows[r][1]), rows[r][2] != 0);
      if (rows[r][2] == 0) run_line(rot_t'(rows[r][0]), line_len_t'(rows[r][1]));
    end
    wait_drained();

    // one running line, a full queue behind it, then one command too many
    issue_cmd(rot_t'(1), line_len_t'(2), 1'b0);
    wait_active();
    for (int i = 0; i < `REALIGN_CMD_DEPTH; i++) begin
      issue_cmd(rot_t'(i), line_len_t'(i + 1), 1'b0);
    end
    assert (cmd_full) else fail_run($sformatf("ERR %0t: cmd_full_o low with a full queue", $time));
    issue_cmd(rot_t'(3), line_len_t'(2), 1'b1);
    run_line(rot_t'(1), line_len_t'(2));
    for (int i = 0; i < `REALIGN_CMD_DEPTH; i++) begin
      run_line(rot_t'(i), line_len_t'(i + 1));
    end
    wait_drained();

    // beat while idle
    @(posedge clk);
    in_valid <= 1'b1;
    in_data  <= word_t'($urandom());
    @(posedge clk);
    in_valid <= 1'b0;
    @(negedge clk);
    assert (stray) else fail_run($sformatf("ERR %0t: stray_o did not pulse", $time));
    repeat (4) @(negedge clk);

    assert (lines_done == 16'(accepted))
      else fail_run($sformatf("ERR %0t: lines_done_o %0d, expected %0d", $time,
                              lines_done, accepted));
    assert (!line_active && !cmd_full)
      else fail_run($sformatf("ERR %0t: line_active_o %b cmd_full_o %b, expected both low",
                              $time, line_active, cmd_full));
    $display("TEST PASS");
    $finish;
  end

endmodule

`default_nettype wire
